//--- project.f
+incdir+.
fsmc_pkg.sv
fsmc_pin_sync.sv
fsmc_bus_slave.sv
reg_bank.sv
read_return_mux.sv
fsmc_regs_top.sv
tb_fsmc_regs.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the FSMC register testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fsmc_regs -f project.f

# pass only if the pass line shows up in the output
./obj_dir/Vtb_fsmc_regs | tee /dev/stderr | grep -x "TESTBENCH PASSED" > /dev/null

echo "run.sh: simulation ok"

//--- tb_fsmc_regs.sv
// testbench for the FSMC register block, the TB plays the bus host
// fixed 6-clock bus phases, so NOE falls well after the 4-clock prefetch
// host lines change 2 ns after the rising edge, outputs are sampled there too
// no tristate pad here, ad_bus carries only what the host drives
`timescale 1ns/1ps
`include "fsmc_config.svh"

module tb_fsmc_regs;

    localparam int sel_w         = `FSMC_SEL_WIDTH;
    localparam int ofs_w         = `FSMC_OFS_WIDTH;
    localparam int mid_w         = `FSMC_AD_WIDTH - sel_w - ofs_w;  // ignored address bits
    localparam int data_w        = `FSMC_DATA_WIDTH;
    localparam int phase_clocks  = 6;
    localparam int rise_timeout  = 10;                      // clocks for the drive to start
    localparam int release_limit = `FSMC_HOLD_CYCLES + 3;   // clocks for the drive to end

    logic                      clk;
    logic                      rst_n;
    logic                      nadv;
    logic                      nwe;
    logic                      noe;
    logic [`FSMC_AD_WIDTH-1:0] ad_bus;
    logic [`FSMC_AD_WIDTH-1:0] ad_drive;
    logic                      ad_drive_en;

    logic [data_w-1:0] model [`FSMC_NUM_BANKS][`FSMC_BANK_DEPTH];  // expected register contents
    logic [31:0]       lfsr_q;
    int                checks;
    int                errors;
    event              hung_ev;    // a wait ran out

    fsmc_regs_top fsmc_regs_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .nadv        (nadv),
        .nwe         (nwe),
        .noe         (noe),
        .ad_bus      (ad_bus),
        .ad_drive    (ad_drive),
        .ad_drive_en (ad_drive_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ============================================================
    // random bits, Galois LFSR with taps 32,22,2,1
    // ============================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};  // one step per bit
        end
    endtask

    // ============================================================
    // checks
    // ============================================================
    task automatic check_word(input string name, input fsmc_pkg::fsmc_data_t got,
                              input fsmc_pkg::fsmc_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_drive(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic fsmc_pkg::fsmc_data_t model_data(input int bank, input int ofs);
        fsmc_pkg::fsmc_data_t e;
        e.pad  = '0;             // upper lines driven as zero
        e.data = model[bank][ofs];
        return e;
    endfunction

    // ============================================================
    // bus host
    // ============================================================
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // one bus phase, drive enable checked every clock
    task automatic hold_phase(input logic exp_en);
        repeat (phase_clocks) begin
            next_cycle();
            check_drive("ad_drive_en", ad_drive_en, exp_en);
        end
    endtask

    function automatic fsmc_pkg::fsmc_word_u addr_word(input int bank, input logic [31:0] mid,
                                                       input int ofs);
        fsmc_pkg::fsmc_word_u w;
        w.addr.bank   = bank[sel_w-1:0];
        w.addr.unused = mid[mid_w-1:0];
        w.addr.offset = ofs[ofs_w-1:0];
        return w;
    endfunction

    task automatic bus_write(input int bank, input logic [31:0] mid, input int ofs,
                             input logic [data_w-1:0] d);
        fsmc_pkg::fsmc_word_u w;
        ad_bus = addr_word(bank, mid, ofs);
        nwe    = 1'b0;      // low at NADV rising marks a write
        nadv   = 1'b0;
        hold_phase(1'b0);
        nadv = 1'b1;
        hold_phase(1'b0);
        w.data.pad  = '0;
        w.data.data = d;
        ad_bus      = w;
        hold_phase(1'b0);
        nwe = 1'b1;         // write taken on this edge
        hold_phase(1'b0);
        model[bank][ofs] = d;   // middle bits play no part
    endtask

    task automatic bus_read(input int bank, input logic [31:0] mid, input int ofs,
                            output fsmc_pkg::fsmc_word_u got);
        int n;
        ad_bus = addr_word(bank, mid, ofs);
        nwe    = 1'b1;
        nadv   = 1'b0;
        hold_phase(1'b0);
        nadv = 1'b1;
        hold_phase(1'b0);
        ad_bus = '0;        // host lets go of the lines
        noe    = 1'b0;
        n      = 0;
        while (!ad_drive_en && n < rise_timeout) begin
            next_cycle();
            n++;
        end
        if (!ad_drive_en) begin
            errors++;
            $display("timeout: ad_drive_en did not rise after NOE went low");
            -> hung_ev;
        end
        repeat (2) begin
            next_cycle();
            check_drive("ad_drive_en", ad_drive_en, 1'b1);  // NOE still low
        end
        got = ad_drive;
        noe = 1'b1;
        n   = 0;
        while (ad_drive_en && n < release_limit) begin
            next_cycle();
            n++;
        end
        if (ad_drive_en) begin
            errors++;
            $display("bus still driven %0d clocks after NOE went high", release_limit);
        end
        repeat (2) begin
            next_cycle();
            check_drive("ad_drive_en", ad_drive_en, 1'b0);  // idle again
        end
    endtask

    task automatic read_and_compare(input int bank, input logic [31:0] mid, input int ofs);
        fsmc_pkg::fsmc_word_u got;
        bus_read(bank, mid, ofs, got);
        check_word("ad_drive", got.data, model_data(bank, ofs));
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        $display("test %0d %s: %0d errors", num, name, errors - err_start);
    endtask

    // a wait that ran out ends the run here
    initial begin
        @(hung_ev);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        logic [31:0] r;
        logic [31:0] mid;
        logic [31:0] mid_b;
        logic [31:0] d;
        int          b;
        int          o;
        int          err0;
        rst_n  = 1'b0;
        nadv   = 1'b1;
        nwe    = 1'b1;
        noe    = 1'b1;
        ad_bus = '0;
        lfsr_q = 32'ha592;
        checks = 0;
        errors = 0;
        for (b = 0; b < `FSMC_NUM_BANKS; b++)
            for (o = 0; o < `FSMC_BANK_DEPTH; o++)
                model[b][o] = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (2) next_cycle();

        err0 = errors;
        for (b = 0; b < `FSMC_NUM_BANKS; b++)
            for (o = 0; o < `FSMC_BANK_DEPTH; o++) begin
                take_bits(mid_w, mid);
                read_and_compare(b, mid, o);
            end
        report_test(1, "read after reset", err0);

        err0 = errors;
        repeat (40) begin
            take_bits(sel_w, r);
            b = int'(r);
            take_bits(ofs_w, r);
            o = int'(r);
            take_bits(mid_w, mid);
            take_bits(data_w, d);
            bus_write(b, mid, o, d[data_w-1:0]);
        end
        for (b = 0; b < `FSMC_NUM_BANKS; b++)
            for (o = 0; o < `FSMC_BANK_DEPTH; o++)
                read_and_compare(b, '0, o);  // whole array against the model
        report_test(2, "random write and readback", err0);

        // same offset in every bank after one write
        err0 = errors;
        for (b = 0; b < `FSMC_NUM_BANKS; b++) begin
            take_bits(ofs_w, r);
            o = int'(r);
            take_bits(mid_w, mid);
            take_bits(data_w, d);
            bus_write(b, mid, o, d[data_w-1:0]);
            for (int k = 0; k < `FSMC_NUM_BANKS; k++)
                read_and_compare(k, mid, o);
        end
        report_test(3, "bank isolation", err0);

        err0 = errors;
        repeat (16) begin
            take_bits(sel_w, r);
            b = int'(r);
            take_bits(ofs_w, r);
            o = int'(r);
            take_bits(mid_w, mid);
            take_bits(mid_w, mid_b);    // other middle bits on the read
            take_bits(data_w, d);
            bus_write(b, mid, o, d[data_w-1:0]);
            read_and_compare(b, mid_b, o);
        end
        report_test(4, "ignored middle address bits", err0);

        err0 = errors;
        repeat (10) begin
            next_cycle();
            check_drive("ad_drive_en", ad_drive_en, 1'b0);
        end
        take_bits(data_w, d);
        bus_write(1, '0, 5, d[data_w-1:0]);
        read_and_compare(1, '0, 5);
        report_test(5, "bus drive enable", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- fsmc_regs_top.sv
// FSMC register subsystem, FSMC_NUM_BANKS banks behind a muxed async bus
// pad is outside: ad_bus is the sampled pins, ad_drive/ad_drive_en feed the tristate
// one clock domain, pins pass a single synchronizer stage
`timescale 1ns/1ps
`include "fsmc_config.svh"

module fsmc_regs_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      nadv,
    input  logic                      nwe,
    input  logic                      noe,
    input  logic [`FSMC_AD_WIDTH-1:0] ad_bus,
    output logic [`FSMC_AD_WIDTH-1:0] ad_drive,
    output logic                      ad_drive_en
);

    fsmc_pkg::pin_events_t  events;
    fsmc_pkg::bank_access_t access;
    fsmc_pkg::bank_return_t rets [`FSMC_NUM_BANKS];
    fsmc_pkg::bank_return_t ret;

    fsmc_pin_sync fsmc_pin_sync_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .nadv   (nadv),
        .nwe    (nwe),
        .noe    (noe),
        .ad_bus (ad_bus),
        .events (events)
    );

    fsmc_bus_slave fsmc_bus_slave_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .events      (events),
        .ret         (ret),
        .access      (access),
        .ad_drive    (ad_drive),
        .ad_drive_en (ad_drive_en)
    );

    // ============================================================
    // register banks, all see the same access
    // ============================================================
    for (genvar b = 0; b < `FSMC_NUM_BANKS; b++) begin : g_bank
        reg_bank #(
            .bank_index (b)
        ) reg_bank_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .access (access),
            .ret    (rets[b])
        );
    end

    read_return_mux read_return_mux_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rets  (rets),
        .ret   (ret)
    );

endmodule

//--- read_return_mux.sv
// gathers the bank read returns into one registered word
// returns are one-hot since one access selects one bank,
// so a plain OR is enough
`timescale 1ns/1ps
`include "fsmc_config.svh"

module read_return_mux (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fsmc_pkg::bank_return_t rets [`FSMC_NUM_BANKS],
    output fsmc_pkg::bank_return_t ret
);

    fsmc_pkg::bank_return_t     or_ret;
    logic [`FSMC_NUM_BANKS-1:0] valids;   // for the one-hot check
    logic                       ret_valid_q;
    logic [`FSMC_DATA_WIDTH-1:0] ret_data_q;

    always_comb begin
        or_ret = '0;
        for (int i = 0; i < `FSMC_NUM_BANKS; i++) begin
            or_ret    = or_ret | rets[i];
            valids[i] = rets[i].valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ret_valid_q <= 1'b0;
        else
            ret_valid_q <= or_ret.valid;
    end

    always_ff @(posedge clk) begin
        ret_data_q <= or_ret.data;
    end

    assign ret.valid = ret_valid_q;
    assign ret.data  = ret_data_q;

    // two banks answering means the select decode is broken
    a_one_return: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(valids)
    ) else $error("more than one bank returned data");

endmodule

//--- reg_bank.sv
// one bank of FSMC_BANK_DEPTH words, FSMC_DATA_WIDTH bits each
// acts only on a valid access with its own select bit set
// write lands on the next clock, read data returns one clock after the access
// no stall, every selected access is taken in the cycle it arrives
`timescale 1ns/1ps
`include "fsmc_config.svh"

module reg_bank #(
    parameter int bank_index = 0    // position of this bank in the one-hot select
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fsmc_pkg::bank_access_t access,
    output fsmc_pkg::bank_return_t ret
);

    logic [`FSMC_DATA_WIDTH-1:0] mem [`FSMC_BANK_DEPTH];
    logic                        sel;
    logic                        rd_sel;
    logic                        ret_valid_q;
    logic [`FSMC_DATA_WIDTH-1:0] ret_data_q;

    assign sel    = access.valid && access.bank_sel[bank_index];
    assign rd_sel = sel && !access.write;

    // ============================================================
    // register array
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};  // registers read back zero after reset
        end else if (sel && access.write) begin
            mem[access.offset] <= access.wdata;
        end
    end

    // read path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ret_valid_q <= 1'b0;
        else
            ret_valid_q <= rd_sel;
    end

    always_ff @(posedge clk) begin
        if (rd_sel)
            ret_data_q <= mem[access.offset];  // old word if written same clock
    end

    assign ret.valid = ret_valid_q;
    assign ret.data  = ret_valid_q ? ret_data_q : '0;  // zero when idle, returns OR cleanly

    // ============================================================
    // checks
    // ============================================================
    // a return belongs to a read that selected this bank one clock earlier
    a_ret_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        ret.valid |-> $past(access.valid && access.bank_sel[bank_index] && !access.write)
    ) else $error("bank %0d returned data without a read", bank_index);

endmodule

//--- fsmc_bus_slave.sv
// FSMC cycle decoder, turns each bus cycle into one internal access
// direction is the NWE level at NADV rising: host holds NWE low there for a write
// read is prefetched at NADV rising, host leaves 4+ clocks before NOE falls
// write data is the bus word seen with the NWE rising event
// drive ends FSMC_HOLD_CYCLES clocks after NOE rising, or on a new NADV
`timescale 1ns/1ps
`include "fsmc_config.svh"

module fsmc_bus_slave (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fsmc_pkg::pin_events_t     events,
    input  fsmc_pkg::bank_return_t    ret,
    output fsmc_pkg::bank_access_t    access,
    output logic [`FSMC_AD_WIDTH-1:0] ad_drive,
    output logic                      ad_drive_en
);

    localparam int hold_w = $clog2(`FSMC_HOLD_CYCLES + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_addr_rd,
        st_addr_wr
    } state_t;

    state_t                        state_q;
    fsmc_pkg::fsmc_addr_t          addr_q;      // latched address phase
    fsmc_pkg::fsmc_addr_t          cur_addr;
    fsmc_pkg::fsmc_word_u          drive_word;
    logic [`FSMC_DATA_WIDTH-1:0]   rdata_q;     // read-data register
    logic [hold_w-1:0]             hold_cnt_q;
    logic                          drive_en_q;
    logic                          rd_issue;
    logic                          wr_issue;

    // ============================================================
    // access issue, combinational from the event pulses
    // ============================================================
    always_comb begin
        rd_issue = events.nadv_rise && events.nwe;  // nwe high, read cycle
        wr_issue = events.nwe_rise && (state_q == st_addr_wr);
        // prefetch uses the address on the bus right now
        cur_addr = rd_issue ? events.word.addr : addr_q;

        access.valid    = rd_issue || wr_issue;
        access.write    = wr_issue;
        access.bank_sel = `FSMC_NUM_BANKS'(1) << cur_addr.bank;  // one-hot decode
        access.offset   = cur_addr.offset;
        access.wdata    = events.word.data.data;
    end

    // address and read data, payload only
    always_ff @(posedge clk) begin
        if (events.nadv_rise)
            addr_q <= events.word.addr;
        if (ret.valid)
            rdata_q <= ret.data;
    end

    // ============================================================
    // cycle FSM and drive hold
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            drive_en_q <= 1'b0;
            hold_cnt_q <= '0;
        end else if (events.nadv_fall) begin
            // new cycle starting, drop any drive still in hold
            state_q    <= st_idle;
            drive_en_q <= 1'b0;
            hold_cnt_q <= '0;
        end else if (events.nadv_rise) begin
            state_q <= events.nwe ? st_addr_rd : st_addr_wr;
        end else if (wr_issue) begin
            state_q <= st_idle;     // write done
        end else if (state_q == st_addr_rd) begin
            if (events.noe_fall) begin
                drive_en_q <= 1'b1;
            end else if (events.noe_rise && drive_en_q) begin
                hold_cnt_q <= hold_w'(`FSMC_HOLD_CYCLES);
            end else if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
                if (hold_cnt_q == hold_w'(1)) begin
                    drive_en_q <= 1'b0;  // hold over
                    state_q    <= st_idle;
                end
            end
        end
    end

    // data view of the bus, upper lines zero
    always_comb begin
        drive_word.data.pad  = '0;
        drive_word.data.data = rdata_q;
    end

    assign ad_drive    = drive_word;
    assign ad_drive_en = drive_en_q;

    // ============================================================
    // checks
    // ============================================================
    // never fight the host during a write cycle
    a_no_drive_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == st_addr_wr) |-> !ad_drive_en
    ) else $error("bus driven during a write cycle");

    // banks take one access per clock, strobes must be separated
    a_access_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        access.valid |=> !access.valid
    ) else $error("access valid on two consecutive clocks");

endmodule

//--- fsmc_pin_sync.sv
// one register stage on the async FSMC pins, then edge detection
// all levels, pulses and the bus word come out registered and aligned,
// two clocks after the pin change
// only one stage, a rare metastable sample is not filtered
`timescale 1ns/1ps
`include "fsmc_config.svh"

module fsmc_pin_sync (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      nadv,
    input  logic                      nwe,
    input  logic                      noe,
    input  logic [`FSMC_AD_WIDTH-1:0] ad_bus,
    output fsmc_pkg::pin_events_t     events
);

    logic [2:0]                sync_q;      // {nadv, nwe, noe}, first stage
    logic [2:0]                lvl_q;       // previous copy, also the output level
    logic [2:0]                rise_q;
    logic [2:0]                fall_q;
    logic [`FSMC_AD_WIDTH-1:0] sync_bus_q;
    logic [`FSMC_AD_WIDTH-1:0] word_q;

    // ============================================================
    // pin levels and edges
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 3'b111;   // all strobes inactive
            lvl_q  <= 3'b111;
            rise_q <= 3'b000;
            fall_q <= 3'b000;
        end else begin
            sync_q <= {nadv, nwe, noe};
            lvl_q  <= sync_q;
            rise_q <= sync_q & ~lvl_q;  // low last clock, high now
            fall_q <= ~sync_q & lvl_q;
        end
    end

    // bus word follows the same two stages so it lines up with the edges
    always_ff @(posedge clk) begin
        sync_bus_q <= ad_bus;
        word_q     <= sync_bus_q;
    end

    always_comb begin
        events.nadv      = lvl_q[2];
        events.nwe       = lvl_q[1];
        events.noe       = lvl_q[0];
        events.nadv_rise = rise_q[2];
        events.nadv_fall = fall_q[2];
        events.nwe_rise  = rise_q[1];
        events.nwe_fall  = fall_q[1];
        events.noe_rise  = rise_q[0];
        events.noe_fall  = fall_q[0];
        events.word      = word_q;  // raw bits into the union
    end

endmodule

//--- fsmc_pkg.sv
// types shared by the FSMC register block
// the bus word is one 18-bit value read two ways, as address or as data
// middle address bits are carried along but never decoded
`include "fsmc_config.svh"

package fsmc_pkg;

    // ============================================================
    // bus word views
    // ============================================================
    typedef struct packed {
        logic [`FSMC_SEL_WIDTH-1:0]                                  bank;    // bank select
        logic [`FSMC_AD_WIDTH-`FSMC_SEL_WIDTH-`FSMC_OFS_WIDTH-1:0]   unused;  // ignored
        logic [`FSMC_OFS_WIDTH-1:0]                                  offset;  // word in bank
    } fsmc_addr_t;

    typedef struct packed {
        logic [`FSMC_AD_WIDTH-`FSMC_DATA_WIDTH-1:0] pad;   // upper lines, zero on drive
        logic [`FSMC_DATA_WIDTH-1:0]                data;
    } fsmc_data_t;

    // same lines, address phase or data phase
    typedef union packed {
        fsmc_addr_t addr;
        fsmc_data_t data;
    } fsmc_word_u;

    // ============================================================
    // internal access and read return
    // ============================================================
    typedef struct packed {
        logic                        valid;     // one-clock strobe, no ready
        logic                        write;     // 0 = read
        logic [`FSMC_NUM_BANKS-1:0]  bank_sel;  // one-hot
        logic [`FSMC_OFS_WIDTH-1:0]  offset;
        logic [`FSMC_DATA_WIDTH-1:0] wdata;
    } bank_access_t;

    typedef struct packed {
        logic                        valid;
        logic [`FSMC_DATA_WIDTH-1:0] data;
    } bank_return_t;

    // synchronized pins and their edge pulses
    typedef struct packed {
        logic       nadv;       // levels, active low
        logic       nwe;
        logic       noe;
        logic       nadv_rise;
        logic       nadv_fall;
        logic       nwe_rise;
        logic       nwe_fall;
        logic       noe_rise;
        logic       noe_fall;
        fsmc_word_u word;       // bus as seen with these edges
    } pin_events_t;

endpackage

//--- fsmc_config.svh
// bus geometry and timing for the FSMC register block
// muxed bus is one word of address, then one word of data on the same lines
// upper select bits pick the bank, low offset bits pick the word
// FSMC_HOLD_CYCLES must be at least 1
// FSMC_NUM_BANKS and FSMC_BANK_DEPTH are powers of two
`ifndef FSMC_CONFIG_SVH
`define FSMC_CONFIG_SVH

// ============================================================
// bus and data widths
// ============================================================
`define FSMC_AD_WIDTH     18  // multiplexed AD lines
`define FSMC_DATA_WIDTH   16  // one register word

// ============================================================
// register array shape
// ============================================================
`define FSMC_NUM_BANKS    4   // from the 2 select bits
`define FSMC_BANK_DEPTH   16  // words per bank

// derived field widths of the address word
`define FSMC_SEL_WIDTH    $clog2(`FSMC_NUM_BANKS)
`define FSMC_OFS_WIDTH    $clog2(`FSMC_BANK_DEPTH)

// clocks the slave keeps driving after NOE goes high
`define FSMC_HOLD_CYCLES  2

`endif
